//--- design/rvfi_check_pkg.sv
package rvfi_check_pkg;

    localparam int xlen = 32; // Data width of the core being checked.

    // One retired instruction as the core reports it.
    typedef struct packed {
        logic            valid;
        logic [31:0]     insn;
        logic [xlen-1:0] pc_rdata;
        logic [xlen-1:0] pc_wdata;
        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic [4:0]      rd_addr;
        logic [xlen-1:0] rs1_rdata;
        logic [xlen-1:0] rs2_rdata;
        logic [xlen-1:0] rd_wdata;
        logic            trap;
        logic [3:0]      mem_rmask;
        logic [3:0]      mem_wmask;
    } rvfi_retire_t;

    // What a checker expects the retirement to look like.
    typedef struct packed {
        logic            valid;
        logic            trap;
        logic [4:0]      rs1_addr;
        logic [4:0]      rs2_addr;
        logic [4:0]      rd_addr;
        logic [xlen-1:0] rd_wdata;
        logic [xlen-1:0] pc_wdata;
        logic [3:0]      mem_rmask;
        logic [3:0]      mem_wmask;
    } insn_spec_t;

    // Registered outcome of one compare cycle.
    typedef struct packed {
        logic            checked;
        logic            mismatch;
        logic [xlen-1:0] pc;
        logic [31:0]     insn;
    } check_event_t;

    // Bit positions in the six-bit enable mask.
    localparam int en_rol  = 0;
    localparam int en_ror  = 1;
    localparam int en_rori = 2;
    localparam int en_andn = 3;
    localparam int en_orn  = 4;
    localparam int en_xnor = 5;

    // APB byte offsets of the register block.
    localparam logic [4:0] reg_ctrl      = 5'h00;
    localparam logic [4:0] reg_checked   = 5'h04;
    localparam logic [4:0] reg_mismatch  = 5'h08;
    localparam logic [4:0] reg_fail_pc   = 5'h0C;
    localparam logic [4:0] reg_fail_insn = 5'h10;

endpackage

//--- design/insn_rotate_checker.sv
`timescale 1ns/1ps

module insn_rotate_checker (
    input  rvfi_check_pkg::rvfi_retire_t retire,
    input  logic [2:0]                   en,     // Enables for rol, ror and rori.
    output rvfi_check_pkg::insn_spec_t   spec
);

    logic                              dec_rol;
    logic                              dec_ror;
    logic                              dec_rori;
    logic [4:0]                        shamt;
    logic [2*rvfi_check_pkg::xlen-1:0] doubled;
    logic [2*rvfi_check_pkg::xlen-1:0] shifted_left;
    logic [2*rvfi_check_pkg::xlen-1:0] shifted_right;
    logic [rvfi_check_pkg::xlen-1:0]   result_rol;
    logic [rvfi_check_pkg::xlen-1:0]   result_ror;
    logic [rvfi_check_pkg::xlen-1:0]   result;

    // Mask and match values of the Zbb rotate encodings.
    assign dec_rol  = retire.valid && ((retire.insn & 32'hfe00707f) == 32'h60001033);
    assign dec_ror  = retire.valid && ((retire.insn & 32'hfe00707f) == 32'h60005033);
    assign dec_rori = retire.valid && ((retire.insn & 32'hfc00707f) == 32'h60005013);

    // The immediate form takes its amount from the instruction word.
    assign shamt = dec_rori ? retire.insn[24:20] : retire.rs2_rdata[4:0];

    // Rotating a doubled copy keeps an amount of zero exact.
    assign doubled       = {retire.rs1_rdata, retire.rs1_rdata};
    assign shifted_left  = doubled << shamt;
    assign shifted_right = doubled >> shamt;
    assign result_rol    = shifted_left[2*rvfi_check_pkg::xlen-1:rvfi_check_pkg::xlen];
    assign result_ror    = shifted_right[rvfi_check_pkg::xlen-1:0];

    assign result = dec_rol ? result_rol : result_ror; // rori shares the ror path.

    always_comb begin
        spec           = '0;
        spec.valid     = (dec_rol && en[0]) || (dec_ror && en[1]) || (dec_rori && en[2]);
        spec.trap      = 1'b0;                                    // Rotates never trap.
        spec.rs1_addr  = retire.insn[19:15];
        spec.rs2_addr  = dec_rori ? 5'd0 : retire.insn[24:20];   // No rs2 read for rori.
        spec.rd_addr   = retire.insn[11:7];
        spec.rd_wdata  = (spec.rd_addr != 5'd0) ? result : '0;   // Writes to x0 read zero.
        spec.pc_wdata  = retire.pc_rdata + 32'd4;
        spec.mem_rmask = 4'b0000;
        spec.mem_wmask = 4'b0000;
    end

endmodule

//--- design/insn_logic_neg_checker.sv
`timescale 1ns/1ps

module insn_logic_neg_checker (
    input  rvfi_check_pkg::rvfi_retire_t retire,
    input  logic [2:0]                   en,     // Enables for andn, orn and xnor.
    output rvfi_check_pkg::insn_spec_t   spec
);

    logic                            dec_andn;
    logic                            dec_orn;
    logic                            dec_xnor;
    logic [rvfi_check_pkg::xlen-1:0] result_andn;
    logic [rvfi_check_pkg::xlen-1:0] result_orn;
    logic [rvfi_check_pkg::xlen-1:0] result_xnor;
    logic [rvfi_check_pkg::xlen-1:0] result;

    // All three share funct7 0100000 and differ only in funct3.
    assign dec_andn = retire.valid && ((retire.insn & 32'hfe00707f) == 32'h40007033);
    assign dec_orn  = retire.valid && ((retire.insn & 32'hfe00707f) == 32'h40006033);
    assign dec_xnor = retire.valid && ((retire.insn & 32'hfe00707f) == 32'h40004033);

    assign result_andn = retire.rs1_rdata & ~retire.rs2_rdata;
    assign result_orn  = retire.rs1_rdata | ~retire.rs2_rdata;
    assign result_xnor = ~(retire.rs1_rdata ^ retire.rs2_rdata);

    // At most one decode is high at a time.
    assign result = ({rvfi_check_pkg::xlen{dec_andn}} & result_andn) |
                    ({rvfi_check_pkg::xlen{dec_orn}}  & result_orn)  |
                    ({rvfi_check_pkg::xlen{dec_xnor}} & result_xnor);

    always_comb begin
        spec           = '0;
        spec.valid     = (dec_andn && en[0]) || (dec_orn && en[1]) || (dec_xnor && en[2]);
        spec.trap      = 1'b0;
        spec.rs1_addr  = retire.insn[19:15];
        spec.rs2_addr  = retire.insn[24:20];                    // Register-register forms.
        spec.rd_addr   = retire.insn[11:7];
        spec.rd_wdata  = (spec.rd_addr != 5'd0) ? result : '0;
        spec.pc_wdata  = retire.pc_rdata + 32'd4;               // Straight-line flow.
        spec.mem_rmask = 4'b0000;
        spec.mem_wmask = 4'b0000;
    end

endmodule

//--- design/retire_compare.sv
`timescale 1ns/1ps

module retire_compare (
    input  logic                         clock,
    input  logic                         rst,
    input  rvfi_check_pkg::rvfi_retire_t retire,
    input  rvfi_check_pkg::insn_spec_t   rot_spec,
    input  rvfi_check_pkg::insn_spec_t   lneg_spec,
    output rvfi_check_pkg::check_event_t check_event
);

    rvfi_check_pkg::insn_spec_t sel_spec;
    logic [7:0]                 field_diff;
    logic                       any_diff;

    // The decodes are disjoint, so a simple priority select is enough.
    assign sel_spec = rot_spec.valid ? rot_spec : lneg_spec;

    // One bit per compared field, kept apart for easier waveform debug.
    assign field_diff[0] = retire.trap      != sel_spec.trap;
    assign field_diff[1] = retire.rs1_addr  != sel_spec.rs1_addr;
    assign field_diff[2] = retire.rs2_addr  != sel_spec.rs2_addr;
    assign field_diff[3] = retire.rd_addr   != sel_spec.rd_addr;
    assign field_diff[4] = retire.rd_wdata  != sel_spec.rd_wdata;
    assign field_diff[5] = retire.pc_wdata  != sel_spec.pc_wdata;
    assign field_diff[6] = retire.mem_rmask != sel_spec.mem_rmask;
    assign field_diff[7] = retire.mem_wmask != sel_spec.mem_wmask;

    assign any_diff = |field_diff;

    // Control half of the event register.
    always_ff @(posedge clock) begin
        if (rst) begin
            check_event.checked  <= 1'b0;
            check_event.mismatch <= 1'b0;
        end else begin
            check_event.checked  <= sel_spec.valid;             // Spec valid implies retire valid.
            check_event.mismatch <= sel_spec.valid && any_diff;
        end
    end

    // Payload half, only meaningful while checked is high.
    always_ff @(posedge clock) begin
        if (sel_spec.valid) begin
            check_event.pc   <= retire.pc_rdata;
            check_event.insn <= retire.insn;
        end
    end

endmodule

//--- design/check_apb_regs.sv
`timescale 1ns/1ps

module check_apb_regs #(
    parameter int cnt_width = 16
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic [4:0]                   paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    input  rvfi_check_pkg::check_event_t check_event,
    output logic [5:0]                   en,
    output logic                         fail
);

    logic [cnt_width-1:0]            checked_cnt;
    logic [cnt_width-1:0]            mismatch_cnt;
    logic [rvfi_check_pkg::xlen-1:0] fail_pc;
    logic [31:0]                     fail_insn;
    logic                            access;
    logic                            addr_err;
    logic                            ro_err;
    logic                            ctrl_wr;
    logic                            clear;
    logic [31:0]                     rdata;

    assign access = psel && penable;
    assign pready = 1'b1; // No wait states.

    // CTRL is the only writable register.
    always_comb begin
        rdata    = '0;
        addr_err = 1'b0;
        ro_err   = pwrite;
        case (paddr)
            rvfi_check_pkg::reg_ctrl: begin
                rdata  = {26'd0, en};                           // Clear bit always reads zero.
                ro_err = 1'b0;
            end
            rvfi_check_pkg::reg_checked:   rdata = 32'(checked_cnt);
            rvfi_check_pkg::reg_mismatch:  rdata = 32'(mismatch_cnt);
            rvfi_check_pkg::reg_fail_pc:   rdata = fail_pc;
            rvfi_check_pkg::reg_fail_insn: rdata = fail_insn;
            default: begin
                addr_err = 1'b1;
                ro_err   = 1'b0;
            end
        endcase
    end

    assign prdata  = rdata;
    assign pslverr = access && (addr_err || ro_err);

    assign ctrl_wr = access && pwrite && (paddr == rvfi_check_pkg::reg_ctrl);
    assign clear   = ctrl_wr && pwdata[8]; // Write-one clear of status.

    always_ff @(posedge clock) begin
        if (rst) begin
            en <= '1;                                           // Everything checked out of reset.
        end else if (ctrl_wr) begin
            en <= pwdata[5:0];
        end
    end

    // A clear takes priority and drops any event in the same cycle.
    always_ff @(posedge clock) begin
        if (rst || clear) begin
            checked_cnt  <= '0;
            mismatch_cnt <= '0;
            fail         <= 1'b0;
            fail_pc      <= '0;
            fail_insn    <= '0;
        end else if (check_event.checked) begin
            if (checked_cnt != '1) begin
                checked_cnt <= checked_cnt + 1'b1;              // Saturates at all ones.
            end
            if (check_event.mismatch) begin
                if (mismatch_cnt != '1) begin
                    mismatch_cnt <= mismatch_cnt + 1'b1;
                end
                if (!fail) begin
                    fail      <= 1'b1;                          // Only the first fail is kept.
                    fail_pc   <= check_event.pc;
                    fail_insn <= check_event.insn;
                end
            end
        end
    end

endmodule

//--- design/rvfi_check_top.sv
`timescale 1ns/1ps

module rvfi_check_top #(
    parameter int cnt_width = 16
) (
    input  logic                         clock,
    input  logic                         rst,
    input  rvfi_check_pkg::rvfi_retire_t retire,
    input  logic [4:0]                   paddr,
    input  logic                         psel,
    input  logic                         penable,
    input  logic                         pwrite,
    input  logic [31:0]                  pwdata,
    output logic [31:0]                  prdata,
    output logic                         pready,
    output logic                         pslverr,
    output logic                         fail
);

    rvfi_check_pkg::insn_spec_t   rot_spec;
    rvfi_check_pkg::insn_spec_t   lneg_spec;
    rvfi_check_pkg::check_event_t check_event;
    logic [5:0]                   en;
    logic [2:0]                   rot_en;
    logic [2:0]                   lneg_en;

    // Split the mask by its package-defined bit positions.
    assign rot_en  = {en[rvfi_check_pkg::en_rori], en[rvfi_check_pkg::en_ror],
                      en[rvfi_check_pkg::en_rol]};
    assign lneg_en = {en[rvfi_check_pkg::en_xnor], en[rvfi_check_pkg::en_orn],
                      en[rvfi_check_pkg::en_andn]};

    insn_rotate_checker u_rotate (
        .retire (retire),
        .en     (rot_en),
        .spec   (rot_spec)
    );

    insn_logic_neg_checker u_logic_neg (
        .retire (retire),
        .en     (lneg_en),
        .spec   (lneg_spec)
    );

    retire_compare u_compare (
        .clock       (clock),
        .rst         (rst),
        .retire      (retire),
        .rot_spec    (rot_spec),
        .lneg_spec   (lneg_spec),
        .check_event (check_event)
    );

    check_apb_regs #(
        .cnt_width (cnt_width)
    ) u_regs (
        .clock       (clock),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .check_event (check_event),
        .en          (en),
        .fail        (fail)
    );

endmodule

//--- test/rvfi_check_tb.sv
`timescale 1ns/1ps

module rvfi_check_tb;

    localparam int num_rows       = 21;
    localparam int timeout_cycles = num_rows * 4 + 300;

    // Instruction kinds, numbered like the enable mask bits.
    localparam logic [2:0] k_rol  = 3'd0;
    localparam logic [2:0] k_ror  = 3'd1;
    localparam logic [2:0] k_rori = 3'd2;
    localparam logic [2:0] k_andn = 3'd3;
    localparam logic [2:0] k_orn  = 3'd4;
    localparam logic [2:0] k_xnor = 3'd5;

    localparam logic [2:0] c_none     = 3'd0;
    localparam logic [2:0] c_rd_wdata = 3'd1;
    localparam logic [2:0] c_pc_wdata = 3'd2;
    localparam logic [2:0] c_rd_addr  = 3'd3;
    localparam logic [2:0] c_rs2_addr = 3'd4;

    typedef struct packed {
        logic [2:0]  kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;      // Shift amount for rori.
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] pc;
        logic [2:0]  corrupt;
        logic [5:0]  mask;     // Enable mask in force for this row.
        logic        check;    // Read the status registers after this row.
    } row_t;

    logic                         clock;
    logic                         rst;
    rvfi_check_pkg::rvfi_retire_t retire;
    logic [4:0]                   paddr;
    logic                         psel;
    logic                         penable;
    logic                         pwrite;
    logic [31:0]                  pwdata;
    logic [31:0]                  prdata;
    logic                         pready;
    logic                         pslverr;
    logic                         fail;

    row_t        rows [num_rows];
    string       row_names [num_rows];
    int          row_count = 0;
    logic [31:0] rng = 32'd52753;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;

    logic [5:0]  cur_mask;
    int          exp_checked;
    int          exp_mismatch;
    logic        exp_fail;
    logic [31:0] exp_fail_pc;
    logic [31:0] exp_fail_insn;

    rvfi_check_top #(
        .cnt_width (16)
    ) DUT (
        .clock   (clock),
        .rst     (rst),
        .retire  (retire),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .fail    (fail)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the test did not finish within %0d cycles", timeout_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Standard Zbb encodings. For rori the rs2 field carries the shift amount.
    function automatic logic [31:0] encode(input row_t r);
        case (r.kind)
            k_rol:   return {7'b0110000, r.rs2, r.rs1, 3'b001, r.rd, 7'b0110011};
            k_ror:   return {7'b0110000, r.rs2, r.rs1, 3'b101, r.rd, 7'b0110011};
            k_rori:  return {7'b0110000, r.rs2, r.rs1, 3'b101, r.rd, 7'b0010011};
            k_andn:  return {7'b0100000, r.rs2, r.rs1, 3'b111, r.rd, 7'b0110011};
            k_orn:   return {7'b0100000, r.rs2, r.rs1, 3'b110, r.rd, 7'b0110011};
            default: return {7'b0100000, r.rs2, r.rs1, 3'b100, r.rd, 7'b0110011};
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input row_t r);
        logic [31:0] x;
        int          s;
        x = r.rs1_data;
        s = (r.kind == k_rori) ? int'(r.rs2) : int'(r.rs2_data[4:0]);
        case (r.kind)
            k_rol:   return (s == 0) ? x : ((x << s) | (x >> (32 - s)));
            k_ror,
            k_rori:  return (s == 0) ? x : ((x >> s) | (x << (32 - s)));
            k_andn:  return x & ~r.rs2_data;
            k_orn:   return x | ~r.rs2_data;
            default: return ~(x ^ r.rs2_data);
        endcase
    endfunction

    // A correct retirement is built first and the selected field is broken after.
    function automatic rvfi_check_pkg::rvfi_retire_t build_retire(input row_t r);
        rvfi_check_pkg::rvfi_retire_t t;
        t           = '0;
        t.valid     = 1'b1;
        t.insn      = encode(r);
        t.pc_rdata  = r.pc;
        t.pc_wdata  = r.pc + 32'd4;
        t.rs1_addr  = r.rs1;
        t.rs2_addr  = (r.kind == k_rori) ? 5'd0 : r.rs2;
        t.rd_addr   = r.rd;
        t.rs1_rdata = r.rs1_data;
        t.rs2_rdata = r.rs2_data;
        t.rd_wdata  = (r.rd == 5'd0) ? 32'd0 : expected_result(r);
        case (r.corrupt)
            c_rd_wdata: t.rd_wdata = t.rd_wdata ^ 32'h1;
            c_pc_wdata: t.pc_wdata = t.pc_wdata + 32'd4;
            c_rd_addr:  t.rd_addr  = t.rd_addr ^ 5'd1;
            c_rs2_addr: t.rs2_addr = t.rs2_addr ^ 5'd7;
            default:    ;
        endcase
        return t;
    endfunction

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic apb_read(input string test, input logic [4:0] addr,
                            output logic [31:0] data, output logic err);
        next_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        next_cycle();
        penable = 1'b1;
        #10;                                // Mid access phase.
        data    = prdata;
        err     = pslverr;
        check_value(test, "pready", 32'd1, {31'd0, pready});
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input string test, input logic [4:0] addr,
                             input logic [31:0] data, output logic err);
        next_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;
        #10;
        err     = pslverr;
        check_value(test, "pready", 32'd1, {31'd0, pready});
        next_cycle();                       // The write lands on this edge.
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_and_check(input string test, input string field,
                                  input logic [4:0] addr, input logic [31:0] expected);
        logic [31:0] data;
        logic        err;
        apb_read(test, addr, data, err);
        check_value(test, field, expected, data);
        check_value(test, "pslverr", 32'd0, {31'd0, err});
    endtask

    task automatic idle_retire();
        next_cycle();
        retire = '0;
    endtask

    // Lets the last retirement reach the counters, then reads all status.
    task automatic check_status(input string test);
        idle_retire();
        next_cycle();
        read_and_check(test, "CHECKED", rvfi_check_pkg::reg_checked, 32'(exp_checked));
        read_and_check(test, "MISMATCH", rvfi_check_pkg::reg_mismatch, 32'(exp_mismatch));
        read_and_check(test, "FAIL_PC", rvfi_check_pkg::reg_fail_pc, exp_fail_pc);
        read_and_check(test, "FAIL_INSN", rvfi_check_pkg::reg_fail_insn, exp_fail_insn);
        check_value(test, "fail", {31'd0, exp_fail}, {31'd0, fail});
    endtask

    task automatic add_row(input string name, input logic [2:0] kind, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] d1, input logic [31:0] d2,
                           input logic [31:0] pc, input logic [2:0] corrupt,
                           input logic [5:0] mask, input logic check);
        row_t r;
        r = '{kind, rd, rs1, rs2, d1, d2, pc, corrupt, mask, check};
        rows[row_count]      = r;
        row_names[row_count] = name;
        row_count++;
    endtask

    task automatic fill_table();
        add_row("rol_basic", k_rol, 5, 6, 7, 32'h80000001, 32'd1, 32'h1000, c_none, 6'h3f, 0);
        add_row("rol_shamt0", k_rol, 5, 6, 7, 32'h12345678, 32'h20, 32'h1004, c_none, 6'h3f, 0);
        add_row("ror_shamt31", k_ror, 8, 9, 10, 32'h3, 32'd31, 32'h1008, c_none, 6'h3f, 0);
        add_row("rori_imm0", k_rori, 11, 12, 0, 32'hdeadbeef, 32'd0, 32'h100c, c_none, 6'h3f, 0);
        add_row("rori_imm31", k_rori, 11, 12, 31, 32'hdeadbeef, 0, 32'h1010, c_none, 6'h3f, 0);
        add_row("rol_random", k_rol, 13, 14, 15, next_rand(), next_rand(), 32'h1014, c_none,
                6'h3f, 0);
        add_row("ror_random", k_ror, 13, 14, 15, next_rand(), next_rand(), 32'h1018, c_none,
                6'h3f, 1);
        add_row("andn_random", k_andn, 1, 2, 3, next_rand(), next_rand(), 32'h1100, c_none,
                6'h3f, 0);
        add_row("orn_random", k_orn, 4, 5, 6, next_rand(), next_rand(), 32'h1104, c_none,
                6'h3f, 0);
        add_row("xnor_random", k_xnor, 7, 8, 9, next_rand(), next_rand(), 32'h1108, c_none,
                6'h3f, 0);
        add_row("andn_rd_x0", k_andn, 0, 2, 3, next_rand(), next_rand(), 32'h110c, c_none,
                6'h3f, 1);
        add_row("ror_bad_wdata", k_ror, 4, 5, 6, 32'hcafef00d, 32'd9, 32'h2000, c_rd_wdata,
                6'h3f, 0);
        add_row("xnor_bad_pc", k_xnor, 7, 8, 9, next_rand(), next_rand(), 32'h2004, c_pc_wdata,
                6'h3f, 0);
        add_row("orn_bad_rd", k_orn, 10, 11, 12, next_rand(), next_rand(), 32'h2008, c_rd_addr,
                6'h3f, 1);
        add_row("rol_x0_write", k_rol, 0, 1, 2, 32'h1, 32'd3, 32'h2100, c_rd_wdata, 6'h3f, 0);
        add_row("rori_rs2_set", k_rori, 3, 4, 5, 32'h0f0f0f0f, 0, 32'h2104, c_rs2_addr,
                6'h3f, 1);
        add_row("rol_disabled", k_rol, 5, 6, 7, next_rand(), next_rand(), 32'h3000, c_none,
                6'h3e, 0);
        add_row("rol_disabled_bad", k_rol, 5, 6, 7, next_rand(), next_rand(), 32'h3004,
                c_rd_wdata, 6'h3e, 0);
        add_row("andn_enabled", k_andn, 1, 2, 3, next_rand(), next_rand(), 32'h3008, c_none,
                6'h3e, 0);
        add_row("orn_enabled_bad", k_orn, 1, 2, 3, next_rand(), next_rand(), 32'h300c,
                c_pc_wdata, 6'h3e, 1);
        add_row("rori_reenabled", k_rori, 9, 10, 17, next_rand(), 0, 32'h3010, c_none,
                6'h3f, 1);
    endtask

    task automatic apply_row(input int i);
        row_t r;
        r = rows[i];
        next_cycle();
        retire = build_retire(r);
        if (cur_mask[r.kind]) begin
            exp_checked++;
            if (r.corrupt != c_none) begin
                exp_mismatch++;
                if (!exp_fail) begin
                    exp_fail      = 1'b1;
                    exp_fail_pc   = r.pc;
                    exp_fail_insn = encode(r);
                end
            end
        end
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        rst           = 1'b1;
        retire        = '0;
        paddr         = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        pwdata        = '0;
        cur_mask      = 6'h3f;              // Reset value of the mask.
        exp_checked   = 0;
        exp_mismatch  = 0;
        exp_fail      = 1'b0;
        exp_fail_pc   = '0;
        exp_fail_insn = '0;
        fill_table();
        repeat (10) @(posedge clock);
        #2;
        rst = 1'b0;

        for (int i = 0; i < row_count; i++) begin
            if (rows[i].mask != cur_mask) begin
                idle_retire();
                apb_write(row_names[i], rvfi_check_pkg::reg_ctrl, {26'd0, rows[i].mask}, err);
                check_value(row_names[i], "CTRL write pslverr", 32'd0, {31'd0, err});
                cur_mask = rows[i].mask;
            end
            apply_row(i);                   // Rows without a check retire back to back.
            if (rows[i].check) begin
                check_status(row_names[i]);
            end
        end

        apb_write("clear", rvfi_check_pkg::reg_ctrl, 32'h13f, err);
        check_value("clear", "CTRL write pslverr", 32'd0, {31'd0, err});
        exp_checked   = 0;
        exp_mismatch  = 0;
        exp_fail      = 1'b0;
        exp_fail_pc   = '0;
        exp_fail_insn = '0;
        check_status("clear");
        read_and_check("clear", "CTRL", rvfi_check_pkg::reg_ctrl, 32'h3f);

        apb_read("bad_offset", 5'h14, data, err);
        check_value("bad_offset", "pslverr", 32'd1, {31'd0, err});
        apb_write("write_checked", rvfi_check_pkg::reg_checked, 32'h5, err);
        check_value("write_checked", "pslverr", 32'd1, {31'd0, err});
        read_and_check("write_checked", "CHECKED", rvfi_check_pkg::reg_checked, 32'd0);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- build.f
design/rvfi_check_pkg.sv
design/insn_rotate_checker.sv
design/insn_logic_neg_checker.sv
design/retire_compare.sv
design/check_apb_regs.sv
design/rvfi_check_top.sv
test/rvfi_check_tb.sv

//--- Bender.yml
package:
  name: rvfi_check

sources:
  - files:
      - design/rvfi_check_pkg.sv
      - design/insn_rotate_checker.sv
      - design/insn_logic_neg_checker.sv
      - design/retire_compare.sv
      - design/check_apb_regs.sv
      - design/rvfi_check_top.sv
  - target: test
    files:
      - test/rvfi_check_tb.sv
